// File: all.f
+incdir+rtl
rtl/gelu_fixed_pkg.sv
rtl/gelu_stream_pkg.sv
rtl/row_link_if.sv
rtl/credit_fifo.sv
rtl/row_feeder.sv
rtl/gelu_lane.sv
rtl/row_collector.sv
rtl/gelu_matrix_top.sv
bench/gelu_checker.sv
bench/gelu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gelu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/gelu_tests.txt
# Columns: test name, then 16 input elements (element 0 first), then 16 expected elements
# All elements are 16-bit hex, two matrices of 16 rows each
m0_r00_small_pos 0000 0123 0245 0367 0489 05AB 06CD 07EF 0801 0912 0A34 0B56 0C78 0D9A 0EBC 0FDE 0000 0099 0162 0252 035D 0479 0599 06B8 07D2 08E4 09F1 0AF8 0BFC 0CFE 0DFF 0F00
m0_r01_small_neg F200 F311 F422 F533 F644 F755 F866 F977 FA88 FB99 FCAA FDBB FECC FFDD F1FF 10FF FFFF FFFE FFFC FFF8 FFF1 FFE4 FFD2 FFB8 FF99 FF79 FF5D FF52 FF62 FF99 0000 1000
m0_r02_pass_10 1000 1101 1202 1303 1404 1505 1606 1707 1808 1909 1A0A 1B0B 1C0C 1D0D 1E0E 1F0F 1000 1100 1200 1300 1400 1500 1600 1700 1800 1900 1A00 1B00 1C00 1D00 1E00 1F00
m0_r03_pass_20 20FF 21FF 22FF 23FF 24FF 25FF 26FF 27FF 28FF 29FF 2AFF 2BFF 2CFF 2DFF 2EFF 2FFF 2000 2100 2200 2300 2400 2500 2600 2700 2800 2900 2A00 2B00 2C00 2D00 2E00 2F00
m0_r04_pass_30 3080 3180 3280 3380 3480 3580 3680 3780 3880 3980 3A80 3B80 3C80 3D80 3E80 3F80 3000 3100 3200 3300 3400 3500 3600 3700 3800 3900 3A00 3B00 3C00 3D00 3E00 3F00
m0_r05_pass_40 4001 4101 4201 4301 4401 4501 4601 4701 4801 4901 4A01 4B01 4C01 4D01 4E01 4F01 4000 4100 4200 4300 4400 4500 4600 4700 4800 4900 4A00 4B00 4C00 4D00 4E00 4F00
m0_r06_pass_50 507F 517F 527F 537F 547F 557F 567F 577F 587F 597F 5A7F 5B7F 5C7F 5D7F 5E7F 5F7F 5000 5100 5200 5300 5400 5500 5600 5700 5800 5900 5A00 5B00 5C00 5D00 5E00 5F00
m0_r07_pass_60 603C 613C 623C 633C 643C 653C 663C 673C 683C 693C 6A3C 6B3C 6C3C 6D3C 6E3C 6F3C 6000 6100 6200 6300 6400 6500 6600 6700 6800 6900 6A00 6B00 6C00 6D00 6E00 6F00
m0_r08_pass_70 70C5 71C5 72C5 73C5 74C5 75C5 76C5 77C5 78C5 79C5 7AC5 7BC5 7CC5 7DC5 7EC5 7FC5 7000 7100 7200 7300 7400 7500 7600 7700 7800 7900 7A00 7B00 7C00 7D00 7E00 7F00
m0_r09_zero_80 8000 8100 8200 8300 8400 8500 8600 8700 8800 8900 8A00 8B00 8C00 8D00 8E00 8F00 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
m0_r10_zero_90 90FF 91FF 92FF 93FF 94FF 95FF 96FF 97FF 98FF 99FF 9AFF 9BFF 9CFF 9DFF 9EFF 9FFF 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
m0_r11_zero_a0 A05A A15A A25A A35A A45A A55A A65A A75A A85A A95A AA5A AB5A AC5A AD5A AE5A AF5A 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
m0_r12_zero_b0 B0A5 B1A5 B2A5 B3A5 B4A5 B5A5 B6A5 B7A5 B8A5 B9A5 BAA5 BBA5 BCA5 BDA5 BEA5 BFA5 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
m0_r13_zero_c0 C011 C111 C211 C311 C411 C511 C611 C711 C811 C911 CA11 CB11 CC11 CD11 CE11 CF11 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
m0_r14_zero_d0 D0EE D1EE D2EE D3EE D4EE D5EE D6EE D7EE D8EE D9EE DAEE DBEE DCEE DDEE DEEE DFEE 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
m0_r15_zero_e0 E077 E177 E277 E377 E477 E577 E677 E777 E877 E977 EA77 EB77 EC77 ED77 EE77 EF77 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
m1_r00_pos_rev 0FDE 0EBC 0D9A 0C78 0B56 0A34 0912 0801 07EF 06CD 05AB 0489 0367 0245 0123 0000 0F00 0DFF 0CFE 0BFC 0AF8 09F1 08E4 07D2 06B8 0599 0479 035D 0252 0162 0099 0000
m1_r01_neg_rev 10FF F1FF FFDD FECC FDBB FCAA FB99 FA88 F977 F866 F755 F644 F533 F422 F311 F200 1000 0000 FF99 FF62 FF52 FF5D FF79 FF99 FFB8 FFD2 FFE4 FFF1 FFF8 FFFC FFFE FFFF
m1_r02_pass_70 70AA 71AA 72AA 73AA 74AA 75AA 76AA 77AA 78AA 79AA 7AAA 7BAA 7CAA 7DAA 7EAA 7FAA 7000 7100 7200 7300 7400 7500 7600 7700 7800 7900 7A00 7B00 7C00 7D00 7E00 7F00
m1_r03_pass_60 60AA 61AA 62AA 63AA 64AA 65AA 66AA 67AA 68AA 69AA 6AAA 6BAA 6CAA 6DAA 6EAA 6FAA 6000 6100 6200 6300 6400 6500 6600 6700 6800 6900 6A00 6B00 6C00 6D00 6E00 6F00
m1_r04_pass_50 50AA 51AA 52AA 53AA 54AA 55AA 56AA 57AA 58AA 59AA 5AAA 5BAA 5CAA 5DAA 5EAA 5FAA 5000 5100 5200 5300 5400 5500 5600 5700 5800 5900 5A00 5B00 5C00 5D00 5E00 5F00
m1_r05_pass_40 40AA 41AA 42AA 43AA 44AA 45AA 46AA 47AA 48AA 49AA 4AAA 4BAA 4CAA 4DAA 4EAA 4FAA 4000 4100 4200 4300 4400 4500 4600 4700 4800 4900 4A00 4B00 4C00 4D00 4E00 4F00
m1_r06_pass_30 30AA 31AA 32AA 33AA 34AA 35AA 36AA 37AA 38AA 39AA 3AAA 3BAA 3CAA 3DAA 3EAA 3FAA 3000 3100 3200 3300 3400 3500 3600 3700 3800 3900 3A00 3B00 3C00 3D00 3E00 3F00
m1_r07_pass_20 20AA 21AA 22AA 23AA 24AA 25AA 26AA 27AA 28AA 29AA 2AAA 2BAA 2CAA 2DAA 2EAA 2FAA 2000 2100 2200 2300 2400 2500 2600 2700 2800 2900 2A00 2B00 2C00 2D00 2E00 2F00
m1_r08_pass_10 10AA 11AA 12AA 13AA 14AA 15AA 16AA 17AA 18AA 19AA 1AAA 1BAA 1CAA 1DAA 1EAA 1FAA 1000 1100 1200 1300 1400 1500 1600 1700 1800 1900 1A00 1B00 1C00 1D00 1E00 1F00
m1_r09_mix_a 0155 F355 2255 9055 0255 F455 3355 A055 0355 F555 4455 B055 0455 F655 5555 C055 0099 FFFE 2200 0000 0162 FFFC 3300 0000 0252 FFF8 4400 0000 035D FFF1 5500 0000
m1_r10_mix_b 05F0 F7F0 66F0 D0F0 06F0 F8F0 77F0 E1F0 07F0 F9F0 11F0 F0F0 08F0 FAF0 7EF0 F1F0 0479 FFE4 6600 0000 0599 FFD2 7700 0000 06B8 FFB8 1100 0000 07D2 FF99 7E00 0000
m1_r11_mix_c 090F FB0F 180F 800F 0A0F FC0F 290F 810F 0B0F FD0F 3A0F 8F0F 0C0F FE0F 4B0F C30F 08E4 FF79 1800 0000 09F1 FF5D 2900 0000 0AF8 FF52 3A00 0000 0BFC FF62 4B00 0000
m1_r12_mix_d 0D3C FF3C 5C3C 9A3C 0E3C F23C 6D3C AB3C 0F3C F33C 7F3C BC3C 003C F43C 103C CD3C 0CFE FF99 5C00 0000 0DFF FFFF 6D00 0000 0F00 FFFE 7F00 0000 0000 FFFC 1000 0000
m1_r13_edges 0F00 0FFF 1000 10FF 7F00 7FFF 8000 80FF F100 F1FF F200 F2FF FF00 FFFF 0000 00FF 0F00 0F00 1000 1000 7F00 7F00 0000 0000 0000 0000 FFFF FFFF FF99 FF99 0000 0000
m1_r14_ramp 0007 1107 2207 3307 4407 5507 6607 7707 8807 9907 AA07 BB07 CC07 DD07 EE07 FF07 0000 1100 2200 3300 4400 5500 6600 7700 0000 0000 0000 0000 0000 0000 0000 FF99
m1_r15_tails F8C3 F9C3 FAC3 FBC3 FCC3 FDC3 FEC3 FFC3 08C3 09C3 0AC3 0BC3 0CC3 0DC3 0EC3 0FC3 FFD2 FFB8 FF99 FF79 FF5D FF52 FF62 FF99 07D2 08E4 09F1 0AF8 0BFC 0CFE 0DFF 0F00

// File: bench/gelu_tb.sv
// GELU matrix testbench
`timescale 1ns/1ps
`include "gelu_macros.svh"

module gelu_tb;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid_i   = 1'b0;
    gelu_stream_pkg::row_t in_row_i     = '0;
    logic                  in_credit_o;
    logic                  out_valid_o;
    gelu_stream_pkg::row_t out_row_o;
    logic                  out_last_o;
    logic                  out_credit_i = 1'b0;

    gelu_stream_pkg::row_t stim_q [$];
    int send_idx     = 0;
    int in_got       = 0;
    int out_rows     = 0;
    int out_given    = 0;
    int hold_cycles  = 0;
    int cycle_cnt    = 0;
    int setup_errors = 0;
    int timeout_cycles;
    bit running      = 1'b0;
    bit timed_out;

    gelu_matrix_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .in_row_i     (in_row_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_row_o    (out_row_o),
        .out_last_o   (out_last_o),
        .out_credit_i (out_credit_i)
    );

    gelu_checker checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .in_credit_i  (in_credit_o),
        .out_valid_i  (out_valid_o),
        .out_row_i    (out_row_o),
        .out_last_i   (out_last_o),
        .out_credit_i (out_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // Test file with one row of stimulus and expected results per line
    // ======================================================================
    task automatic load_tests();
        int                    fd;
        int                    code;
        string                 name;
        string                 rest;
        logic [15:0]           value;
        gelu_stream_pkg::row_t in_row;
        gelu_stream_pkg::row_t exp_row;
        fd = $fopen("bench/gelu_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/gelu_tests.txt for reading");
            setup_errors++;
        end else begin
            while ($fscanf(fd, "%s", name) == 1) begin
                if (name[0] == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    for (int i = 0; i < 2 * `GELU_DIM; i++) begin
                        code = $fscanf(fd, "%h", value);
                        if (code != 1) begin
                            $display("Test %s has no readable element %0d in the test file",
                                     name, i);
                            setup_errors++;
                        end
                        if (i < `GELU_DIM) in_row[i] = value;
                        else exp_row[i - `GELU_DIM] = value;
                    end
                    // Last row of each matrix carries the end mark
                    checker_i.add_expected(name, exp_row,
                        (stim_q.size() % `GELU_DIM) == `GELU_DIM - 1);
                    stim_q.push_back(in_row);
                end
            end
            $fclose(fd);
        end
    endtask

    // Credits seen by the upstream and rows owed a downstream credit
    always @(posedge clk) begin
        cycle_cnt++;
        if (in_credit_o) in_got++;
        if (out_valid_o) out_rows++;
    end

    always @(negedge clk) begin
        in_valid_i   = 1'b0;
        out_credit_i = 1'b0;
        if (running) begin
            if (send_idx < stim_q.size() && send_idx < `GELU_IN_CREDITS + in_got &&
                ($urandom % 4) != 0) begin
                in_valid_i = 1'b1;
                in_row_i   = stim_q[send_idx];
                send_idx++;
            end
            // Withhold output credits for random stretches
            if (hold_cycles > 0) begin
                hold_cycles--;
            end else if (out_given < out_rows) begin
                out_credit_i = 1'b1;
                out_given++;
                if (($urandom % 4) == 0) hold_cycles = 1 + int'($urandom % 12);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h57f4f815));
        load_tests();
        if (stim_q.size() != 2 * `GELU_DIM) begin
            $display("Test file held %0d rows instead of %0d", stim_q.size(), 2 * `GELU_DIM);
            setup_errors++;
        end
        timeout_cycles = 64 * stim_q.size() + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        running = 1'b1;
        while (checker_i.rows_seen < stim_q.size() && cycle_cnt < timeout_cycles) @(negedge clk);
        timed_out = (checker_i.rows_seen < stim_q.size());
        if (timed_out) begin
            $display("Timed out after %0d cycles", cycle_cnt);
        end else begin
            // Quiet window to catch stray extra rows
            repeat (20) @(negedge clk);
        end
        running = 1'b0;
        checker_i.report_counts(2 * `GELU_DIM);
        if (checker_i.error_count() == 0 && setup_errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: bench/gelu_checker.sv
// GELU result checker
`timescale 1ns/1ps
`include "gelu_macros.svh"

module gelu_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  in_valid_i,
    input logic                  in_credit_i,
    input logic                  out_valid_i,
    input gelu_stream_pkg::row_t out_row_i,
    input logic                  out_last_i,
    input logic                  out_credit_i
);

    // Expected rows in acceptance order
    string                 exp_names [$];
    gelu_stream_pkg::row_t exp_rows  [$];
    logic                  exp_lasts [$];

    int rows_seen    = 0;
    int mismatches   = 0;
    int flow_errors  = 0;
    int missing_rows = 0;
    int rows_sent    = 0;
    int credits_back = 0;
    int out_used     = 0;
    int out_granted  = `GELU_OUT_CREDITS;

    task automatic add_expected(string name, gelu_stream_pkg::row_t row, logic last);
        exp_names.push_back(name);
        exp_rows.push_back(row);
        exp_lasts.push_back(last);
    endtask

    task automatic compare_row();
        string                 name;
        gelu_stream_pkg::row_t row;
        logic                  last;
        if (exp_rows.size() == 0) begin
            $display("Extra output row arrived after %0d rows", rows_seen);
            flow_errors++;
        end else begin
            name = exp_names.pop_front();
            row  = exp_rows.pop_front();
            last = exp_lasts.pop_front();
            for (int j = 0; j < `GELU_DIM; j++) begin
                if (out_row_i[j] !== row[j]) begin
                    $display("MISMATCH %s elem %0d expected %04h actual %04h",
                             name, j, row[j], out_row_i[j]);
                    mismatches++;
                end
            end
            if (out_last_i !== last) begin
                $display("MISMATCH %s last expected %0b actual %0b", name, last, out_last_i);
                mismatches++;
            end
        end
        rows_seen++;
    endtask

    // DUT outputs still hold their pre-edge values here
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_valid_i) rows_sent++;
            if (in_credit_i) credits_back++;
            if (credits_back > rows_sent) begin
                $display("Input credit returned for a row that was never sent");
                flow_errors++;
            end
            if (out_valid_i) begin
                out_used++;
                if (out_used > out_granted) begin
                    $display("Output row %0d was sent without an output credit", out_used);
                    flow_errors++;
                end
                compare_row();
            end
            if (out_credit_i) out_granted++;
        end
    end

    function automatic int error_count();
        return mismatches + flow_errors + missing_rows;
    endfunction

    task automatic report_counts(int expected_rows);
        if (rows_seen < expected_rows) begin
            $display("Only %0d of %0d result rows arrived", rows_seen, expected_rows);
            missing_rows = expected_rows - rows_seen;
        end
        $display("Rows seen %0d, mismatches %0d, flow errors %0d, missing rows %0d",
                 rows_seen, mismatches, flow_errors, missing_rows);
    endtask

endmodule

// File: rtl/gelu_matrix_top.sv
// GELU matrix row stream top
`timescale 1ns/1ps
`include "gelu_macros.svh"

module gelu_matrix_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // Upstream rows, sent only against held credits
    input  logic                  in_valid_i,
    input  gelu_stream_pkg::row_t in_row_i,
    output logic                  in_credit_o,
    // Result rows, last marks the end of a matrix
    output logic                  out_valid_o,
    output gelu_stream_pkg::row_t out_row_o,
    output logic                  out_last_o,
    input  logic                  out_credit_i
);

    // ======================================================================
    // Internal links
    // ======================================================================
    row_link_if #(.credits(`GELU_OUT_CREDITS)) issue_link ();
    row_link_if #(.credits(`GELU_OUT_CREDITS)) result_link ();

    row_feeder u_feeder (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid_i    (in_valid_i),
        .in_row_i      (in_row_i),
        .in_credit_o   (in_credit_o),
        .issue         (issue_link.src),
        .result_credit (result_link.credit_view)
    );

    // ======================================================================
    // One lane per column
    // ======================================================================
    for (genvar i = 0; i < `GELU_DIM; i++) begin : g_lane
        gelu_lane #(
            .lane (i)
        ) u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .issue  (issue_link.dst),
            .result (result_link.src)
        );
    end

    row_collector u_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .result       (result_link.dst),
        .out_valid_o  (out_valid_o),
        .out_row_o    (out_row_o),
        .out_last_o   (out_last_o),
        .out_credit_i (out_credit_i)
    );

endmodule

// File: rtl/row_collector.sv
// Output row collector
`timescale 1ns/1ps
`include "gelu_macros.svh"

module row_collector (
    input  logic                  clk,
    input  logic                  rst_n,
    row_link_if.dst               result,
    output logic                  out_valid_o,
    output gelu_stream_pkg::row_t out_row_o,
    output logic                  out_last_o,
    input  logic                  out_credit_i
);

    // Buffer matches the credits the feeder starts with
    localparam int fifo_depth = result.credits;

    gelu_stream_pkg::tagged_row_t in_item;
    gelu_stream_pkg::tagged_row_t head_item;
    logic                         fifo_empty;
    gelu_stream_pkg::credit_t     out_cnt;

    assign in_item.last = result.last;
    assign in_item.row  = result.row;

    // ======================================================================
    // Result buffer, its pops go back to the feeder as credits
    // ======================================================================
    credit_fifo #(
        .item_t (gelu_stream_pkg::tagged_row_t),
        .depth  (fifo_depth)
    ) u_out_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (result.valid),
        .push_item_i (in_item),
        .pop_i       (out_valid_o),
        .head_o      (head_item),
        .empty_o     (fifo_empty),
        .credit_o    (result.credit)
    );

    // ======================================================================
    // Downstream side
    // ======================================================================
    // Present the head row only while the downstream has granted a slot
    assign out_valid_o = !fifo_empty && (out_cnt != '0);
    assign out_row_o   = head_item.row;
    assign out_last_o  = out_valid_o && head_item.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt <= gelu_stream_pkg::credit_t'(`GELU_OUT_CREDITS);
        end else begin
            out_cnt <= out_cnt
                     + gelu_stream_pkg::credit_t'(out_credit_i)
                     - gelu_stream_pkg::credit_t'(out_valid_o);
        end
    end

    // Downstream must not return more credits than it was given rows
    a_out_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_cnt <= gelu_stream_pkg::credit_t'(`GELU_OUT_CREDITS)
    );

endmodule

// File: rtl/gelu_lane.sv
// GELU column lane
`timescale 1ns/1ps

module gelu_lane #(
    parameter int lane = 0
) (
    input logic     clk,
    input logic     rst_n,
    row_link_if.dst issue,
    row_link_if.src result
);

    gelu_fixed_pkg::elem_t elem_q;

    // This column's element lookup is registered every cycle
    always_ff @(posedge clk) begin
        elem_q <= gelu_fixed_pkg::gelu_lookup(issue.row[lane]);
    end

    assign result.row[lane] = elem_q;

    // Lane 0 carries the row's control alongside its element
    if (lane == 0) begin : g_ctrl
        logic valid_q;
        logic last_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_q <= 1'b0;
                last_q  <= 1'b0;
            end else begin
                valid_q <= issue.valid;
                last_q  <= issue.valid && issue.last;
            end
        end

        assign result.valid = valid_q;
        assign result.last  = last_q;
    end

endmodule

// File: rtl/row_feeder.sv
// Input row feeder
`timescale 1ns/1ps
`include "gelu_macros.svh"

module row_feeder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid_i,
    input  gelu_stream_pkg::row_t in_row_i,
    output logic                  in_credit_o,
    row_link_if.src               issue,
    row_link_if.credit_view       result_credit
);

    localparam int row_cnt_w = $clog2(`GELU_DIM);

    gelu_stream_pkg::row_t    head_row;
    logic                     fifo_empty;
    logic                     issue_fire;
    gelu_stream_pkg::credit_t credit_cnt;
    logic [row_cnt_w-1:0]     row_cnt;

    // ======================================================================
    // Input buffer whose pops are the upstream's credits
    // ======================================================================
    credit_fifo #(
        .item_t (gelu_stream_pkg::row_t),
        .depth  (`GELU_IN_CREDITS)
    ) u_in_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (in_valid_i),
        .push_item_i (in_row_i),
        .pop_i       (issue_fire),
        .head_o      (head_row),
        .empty_o     (fifo_empty),
        .credit_o    (in_credit_o)
    );

    // ======================================================================
    // Issue to the lanes
    // ======================================================================
    // One row per cycle while a collector slot is known to be free
    assign issue_fire  = !fifo_empty && (credit_cnt != '0);
    assign issue.valid = issue_fire;
    assign issue.row   = head_row;
    assign issue.last  = (row_cnt == row_cnt_w'(`GELU_DIM - 1));

    // Collector slots are spent on issue and returned on its pops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= gelu_stream_pkg::credit_t'(result_credit.credits);
        end else begin
            credit_cnt <= credit_cnt
                        + gelu_stream_pkg::credit_t'(result_credit.credit)
                        - gelu_stream_pkg::credit_t'(issue_fire);
        end
    end

    // Position of the next issued row inside its matrix
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (issue_fire) begin
            row_cnt <= issue.last ? '0 : row_cnt + 1'b1;
        end
    end

    // The collector cannot hand back more slots than it has
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_cnt <= gelu_stream_pkg::credit_t'(result_credit.credits)
    );

endmodule

// File: rtl/credit_fifo.sv
// Credit-returning FIFO
`timescale 1ns/1ps

module credit_fifo #(
    parameter type item_t = logic,
    parameter int  depth  = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push_i,
    input  item_t push_item_i,
    input  logic  pop_i,
    output item_t head_o,
    output logic  empty_o,
    output logic  credit_o
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    item_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_pop;

    // Circular pointer step, depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty_o  = (count == '0);
    assign do_pop   = pop_i && !empty_o;
    assign head_o   = mem[rd_ptr];
    // Each pop frees a slot, handed back as a credit in the same cycle
    assign credit_o = do_pop;

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_item_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(push_i) - cnt_w'(do_pop);
        end
    end

    // A push into a full FIFO means the sender spent a credit it never had
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push_i |-> (count < cnt_w'(depth))
    );

endmodule

// File: rtl/row_link_if.sv
// Row link between stages
`timescale 1ns/1ps
`include "gelu_macros.svh"

interface row_link_if #(
    // Slots the destination can hold, which is the source's starting credit
    parameter int credits = `GELU_OUT_CREDITS
);

    logic                  valid;
    gelu_stream_pkg::row_t row;
    logic                  last;
    // One pulse per freed slot at the destination
    logic                  credit;

    modport src (
        output valid,
        output row,
        output last,
        input  credit
    );

    modport dst (
        input  valid,
        input  row,
        input  last,
        output credit
    );

    // Credit return only, for a stage that owns the counter but not the data
    modport credit_view (
        input credit
    );

endinterface

// File: rtl/gelu_stream_pkg.sv
// Row stream types
`include "gelu_macros.svh"

package gelu_stream_pkg;

    // One matrix row, element 0 in the low bits
    typedef gelu_fixed_pkg::elem_t [`GELU_DIM-1:0] row_t;

    // Row plus its end-of-matrix mark
    typedef struct packed {
        logic last;
        row_t row;
    } tagged_row_t;

    // Wide enough to hold the larger of the two credit pools
    localparam int CreditMax = (`GELU_IN_CREDITS > `GELU_OUT_CREDITS) ?
                               `GELU_IN_CREDITS : `GELU_OUT_CREDITS;

    typedef logic [$clog2(CreditMax + 1)-1:0] credit_t;

endpackage

// File: rtl/gelu_fixed_pkg.sv
// Q5.10 GELU lookup
`include "gelu_macros.svh"

package gelu_fixed_pkg;

    // One Q5.10 value
    typedef logic [`GELU_ELEM_W-1:0]  elem_t;
    // Table address
    typedef logic [`GELU_INDEX_W-1:0] index_t;

    // ======================================================================
    // 256-entry GELU table, addressed by the upper element bits
    // ======================================================================
    function automatic elem_t gelu_lookup(elem_t x);
        index_t idx;
        elem_t  y;
        idx = x[`GELU_ELEM_W-1 -: `GELU_INDEX_W];
        case (idx) inside
            // Small positive inputs follow the curve
            8'd0:   y = 16'h0000;
            8'd1:   y = 16'h0099;
            8'd2:   y = 16'h0162;
            8'd3:   y = 16'h0252;
            8'd4:   y = 16'h035D;
            8'd5:   y = 16'h0479;
            8'd6:   y = 16'h0599;
            8'd7:   y = 16'h06B8;
            8'd8:   y = 16'h07D2;
            8'd9:   y = 16'h08E4;
            8'd10:  y = 16'h09F1;
            8'd11:  y = 16'h0AF8;
            8'd12:  y = 16'h0BFC;
            8'd13:  y = 16'h0CFE;
            8'd14:  y = 16'h0DFF;
            8'd15:  y = 16'h0F00;
            // Larger inputs pass through, rounded to the index grid
            [8'd16:8'd127]: y = elem_t'({idx, {(`GELU_ELEM_W - `GELU_INDEX_W){1'b0}}});
            // Small negative inputs give the slight dip below zero
            8'd242: y = 16'hFFFF;
            8'd243: y = 16'hFFFE;
            8'd244: y = 16'hFFFC;
            8'd245: y = 16'hFFF8;
            8'd246: y = 16'hFFF1;
            8'd247: y = 16'hFFE4;
            8'd248: y = 16'hFFD2;
            8'd249: y = 16'hFFB8;
            8'd250: y = 16'hFF99;
            8'd251: y = 16'hFF79;
            8'd252: y = 16'hFF5D;
            8'd253: y = 16'hFF52;
            8'd254: y = 16'hFF62;
            8'd255: y = 16'hFF99;
            // Indices 128 to 241 are large negatives, output flushes to zero
            default: y = '0;
        endcase
        return y;
    endfunction

endpackage

// File: rtl/gelu_macros.svh
// GELU build constants
`ifndef GELU_MACROS_SVH
`define GELU_MACROS_SVH

// ==========================================================================
// Matrix shape
// ==========================================================================
// Rows per matrix, also lanes per row
`define GELU_DIM         16
// Q5.10 element width
`define GELU_ELEM_W      16
// Table index, taken from the top bits of an element
`define GELU_INDEX_W     8

// ==========================================================================
// Flow control
// ==========================================================================
// Input FIFO depth and the upstream's starting credits
`define GELU_IN_CREDITS  2
// Credits granted by the downstream after reset
`define GELU_OUT_CREDITS 2

`endif
